// ==== Makefile ====
# Verilator build and run for the vector execute pipeline

VERILATOR ?= verilator
TOP       ?= vx_execute_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# status comes from the search for the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/vx_execute_chk.sv ====
//**********************************************************************
// concurrent checks on reset, stall and flush of the execute pipe
// bound into vx_execute from the testbench
//**********************************************************************
`timescale 1ns/100ps

module vx_execute_chk (
  input logic                  CLK,
  input logic                  nRST,
  input logic                  stall,
  input logic                  flush,
  input vx_pkg::exec_result_t  result
);

  // nothing valid leaves the pipe in reset
  a_reset_idle: assert property (@(posedge CLK) !nRST |-> !result.valid)
    else $error("result.valid high while nRST is low");

  // a stalled edge leaves the hand-off register untouched
  a_stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (stall && !flush) |=> $stable(result))
    else $error("result changed across a stalled edge");

  a_flush_clear: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> !result.valid)
    else $error("result.valid high one edge after flush");

endmodule

// ==== dv/vx_execute_tb.sv ====
//**********************************************************************
// table-driven testbench for the vector execute pipe
// LFSR operands, reference model and an in-order scoreboard
//**********************************************************************
`timescale 1ns/100ps

module vx_execute_tb;

  import vx_pkg::*;

  localparam int DRAIN_LIMIT = 20;

  typedef struct {
    string  name;
    issue_t iss;
    logic   stall;
    logic   flush;
    word_t  res0;
    word_t  res1;
  } step_t;

  typedef struct {
    string name;
    vreg_t vd;
    word_t res0;
    word_t res1;
    int    due;
  } sb_item_t;

  logic         CLK;
  logic         nRST;
  logic         stall;
  logic         flush;
  issue_t       issue;
  exec_result_t result;

  step_t        steps[$];
  sb_item_t     sb[$];
  sb_item_t     cur;
  logic         cur_valid;
  logic [31:0]  lfsr;
  int           adv;

  vx_execute dut0 (
    .CLK    (CLK),
    .nRST   (nRST),
    .stall  (stall),
    .flush  (flush),
    .issue  (issue),
    .result (result)
  );

  bind vx_execute vx_execute_chk chk0 (
    .CLK    (CLK),
    .nRST   (nRST),
    .stall  (stall),
    .flush  (flush),
    .result (result)
  );

  always #5 CLK = ~CLK;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output word_t w);
    w = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[30:0], lfsr[0]};
    end
  endtask

  // sign-extend the element held in the low sew bits
  function automatic word_t ext_low(input word_t w, input sew_t sew);
    if (sew == SEW8) return {{24{w[7]}}, w[7:0]};
    if (sew == SEW16) return {{16{w[15]}}, w[15:0]};
    return w;
  endfunction

  // low sew bits of a word, zero-extended
  function automatic word_t low_bits(input word_t w, input sew_t sew);
    if (sew == SEW8) return {24'd0, w[7:0]};
    if (sew == SEW16) return {16'd0, w[15:0]};
    return w;
  endfunction

  function automatic word_t source_value(input src_type_t t, input word_t v,
                                         input word_t imm, input word_t xs1);
    return (t == SRC_V) ? v : (t == SRC_I) ? imm : (t == SRC_X) ? xs1 : 32'd0;
  endfunction

  function automatic word_t ref_alu(input valu_op_t op, input sew_t sew,
                                    input word_t a, input word_t b);
    logic lt;
    lt = $signed(ext_low(a, sew)) < $signed(ext_low(b, sew));
    case (op)
      VALU_ADD:  return a + b;
      VALU_AND:  return a & b;
      VALU_OR:   return a | b;
      VALU_XOR:  return a ^ b;
      VALU_MIN:  return lt ? a : b;
      VALU_MAX:  return lt ? b : a;
      VALU_MINU: return (a < b) ? a : b;
      default:   return (a < b) ? b : a;
    endcase
  endfunction

  // narrow and full compares disagree with no tie in the low bits
  function automatic logic split_compare(input word_t a, input word_t b, input sew_t sew,
                                         input logic is_signed);
    logic narrow_lt;
    logic full_lt;
    if (is_signed) begin
      narrow_lt = $signed(ext_low(a, sew)) < $signed(ext_low(b, sew));
      full_lt = $signed(a) < $signed(b);
    end else begin
      narrow_lt = low_bits(a, sew) < low_bits(b, sew);
      full_lt = a < b;
    end
    return (low_bits(a, sew) != low_bits(b, sew)) && (narrow_lt != full_lt);
  endfunction

  task automatic add_step(input string name, input valu_op_t op, input src_type_t t1,
                          input src_type_t t2, input sew_t sew, input logic red,
                          input logic vld, input logic stl, input logic fls);
    step_t st;
    word_t w;
    word_t r [NUM_LANES];
    int    tries;
    logic  is_signed;
    logic  steer;
    st.name = name;
    st.stall = stl;
    st.flush = fls;
    st.iss = '0;
    st.iss.valid = vld;
    st.iss.op = op;
    st.iss.rs1_type = t1;
    st.iss.rs2_type = t2;
    st.iss.sew = sew;
    st.iss.reduce = red;
    is_signed = (op == VALU_MIN || op == VALU_MAX);
    steer = (is_signed || op == VALU_MINU || op == VALU_MAXU) && sew != SEW32;
    draw_bits(5, w);
    st.iss.vd = w[4:0];
    draw_bits(32, w);
    st.iss.imm = w;
    draw_bits(32, w);
    st.iss.xs1 = w;
    for (int i = 0; i < NUM_LANES; i++) begin
      draw_bits(32, w);
      st.iss.vs1[i] = w;
      draw_bits(32, w);
      // narrow min/max wants upper bits that mislead the other compare width
      tries = 0;
      while (steer && !split_compare(st.iss.vs1[i], w, sew, is_signed) && tries < 64) begin
        draw_bits(32, w);
        tries++;
      end
      st.iss.vs2[i] = w;
      r[i] = ref_alu(op, sew, source_value(t1, st.iss.vs1[i], st.iss.imm, st.iss.xs1),
                     source_value(t2, st.iss.vs2[i], st.iss.imm, st.iss.xs1));
    end
    st.res0 = red ? ref_alu(op, sew, r[0], r[1]) : r[0];
    st.res1 = r[1];
    steps.push_back(st);
  endtask

  task automatic build_table();
    valu_op_t op_k;
    for (int k = 0; k < 3; k++) begin
      add_step("reset_idle", VALU_ADD, SRC_V, SRC_V, SEW32, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    // every opcode back to back on vector operands
    for (int k = 0; k < 8; k++) begin
      op_k = valu_op_t'(k[2:0]);
      add_step($sformatf("%s_vv", op_k.name()), op_k, SRC_V, SRC_V, SEW32,
               1'b0, 1'b1, 1'b0, 1'b0);
    end
    add_step("add_iv", VALU_ADD, SRC_I, SRC_V, SEW32, 1'b0, 1'b1, 1'b0, 1'b0);
    add_step("add_vx", VALU_ADD, SRC_V, SRC_X, SEW32, 1'b0, 1'b1, 1'b0, 1'b0);
    add_step("or_nv", VALU_OR, SRC_NONE, SRC_V, SEW32, 1'b0, 1'b1, 1'b0, 1'b0);
    add_step("xor_xi", VALU_XOR, SRC_X, SRC_I, SEW32, 1'b0, 1'b1, 1'b0, 1'b0);
    add_step("add_in", VALU_ADD, SRC_I, SRC_NONE, SEW32, 1'b0, 1'b1, 1'b0, 1'b0);
    add_step("and_xx", VALU_AND, SRC_X, SRC_X, SEW32, 1'b0, 1'b1, 1'b0, 1'b0);
    add_step("min_e8", VALU_MIN, SRC_V, SRC_V, SEW8, 1'b0, 1'b1, 1'b0, 1'b0);
    add_step("max_e8", VALU_MAX, SRC_V, SRC_V, SEW8, 1'b0, 1'b1, 1'b0, 1'b0);
    add_step("min_e16", VALU_MIN, SRC_V, SRC_V, SEW16, 1'b0, 1'b1, 1'b0, 1'b0);
    add_step("max_e16", VALU_MAX, SRC_V, SRC_V, SEW16, 1'b0, 1'b1, 1'b0, 1'b0);
    add_step("minu_e8", VALU_MINU, SRC_V, SRC_V, SEW8, 1'b0, 1'b1, 1'b0, 1'b0);
    add_step("maxu_e16", VALU_MAXU, SRC_V, SRC_V, SEW16, 1'b0, 1'b1, 1'b0, 1'b0);
    add_step("redsum", VALU_ADD, SRC_V, SRC_V, SEW32, 1'b1, 1'b1, 1'b0, 1'b0);
    add_step("redxor", VALU_XOR, SRC_V, SRC_V, SEW32, 1'b1, 1'b1, 1'b0, 1'b0);
    add_step("redmin_e16", VALU_MIN, SRC_V, SRC_V, SEW16, 1'b1, 1'b1, 1'b0, 1'b0);
    add_step("redmaxu", VALU_MAXU, SRC_V, SRC_V, SEW32, 1'b1, 1'b1, 1'b0, 1'b0);
    // stalled issues are ignored while the pipe freezes
    add_step("stall_1", VALU_OR, SRC_V, SRC_V, SEW32, 1'b0, 1'b1, 1'b1, 1'b0);
    add_step("stall_2", VALU_OR, SRC_V, SRC_V, SEW32, 1'b0, 1'b1, 1'b1, 1'b0);
    add_step("stall_3", VALU_OR, SRC_V, SRC_V, SEW32, 1'b0, 1'b1, 1'b1, 1'b0);
    add_step("post_stall", VALU_AND, SRC_V, SRC_X, SEW32, 1'b0, 1'b1, 1'b0, 1'b0);
    add_step("pre_flush_a", VALU_MIN, SRC_V, SRC_V, SEW32, 1'b0, 1'b1, 1'b0, 1'b0);
    add_step("pre_flush_b", VALU_MAX, SRC_V, SRC_V, SEW8, 1'b0, 1'b1, 1'b0, 1'b0);
    // flush beats stall
    add_step("flush", VALU_ADD, SRC_V, SRC_V, SEW32, 1'b0, 1'b1, 1'b1, 1'b1);
    add_step("post_flush_a", VALU_XOR, SRC_I, SRC_V, SEW32, 1'b0, 1'b1, 1'b0, 1'b0);
    add_step("post_flush_b", VALU_ADD, SRC_V, SRC_V, SEW32, 1'b1, 1'b1, 1'b0, 1'b0);
  endtask

  // expected pipe state after the coming rising edge
  task automatic advance_model(input step_t st);
    sb_item_t item;
    if (st.flush) begin
      sb.delete();
      cur_valid = 1'b0;
    end else if (!st.stall) begin
      adv++;
      if (st.iss.valid) begin
        item = '{name: st.name, vd: st.iss.vd, res0: st.res0, res1: st.res1, due: adv + 2};
        sb.push_back(item);
      end
      cur_valid = (sb.size() > 0) && (sb[0].due == adv);
      if (cur_valid) begin
        cur = sb.pop_front();
      end
    end
  endtask

  task automatic check_word(input string name, input string field,
                            input word_t exp, input word_t act);
    assert (act === exp) else begin
      $display("** Error %s: %s expected %h, actual %h", name, field, exp, act);
      $display("Test failures found");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic check_output(input string at);
    if (cur_valid) begin
      check_word(cur.name, "valid", 32'd1, 32'(result.valid));
      check_word(cur.name, "vd", 32'(cur.vd), 32'(result.vd));
      check_word(cur.name, "res0", cur.res0, result.res0);
      check_word(cur.name, "res1", cur.res1, result.res1);
    end else begin
      check_word(at, "valid", 32'd0, 32'(result.valid));
    end
  endtask

  initial begin
    step_t idle;
    int    guard;
    CLK = 1'b0;
    nRST = 1'b0;
    stall = 1'b0;
    flush = 1'b0;
    issue = '0;
    lfsr = 32'h376779b7;
    adv = 0;
    cur_valid = 1'b0;
    build_table();
    repeat (3) begin
      @(negedge CLK);
      check_word("reset", "valid", 32'd0, 32'(result.valid));
    end
    nRST = 1'b1;
    foreach (steps[s]) begin
      issue = steps[s].iss;
      stall = steps[s].stall;
      flush = steps[s].flush;
      advance_model(steps[s]);
      @(negedge CLK);
      check_output(steps[s].name);
    end
    // drain the items still in flight
    idle = steps[0];
    idle.name = "drain";
    idle.iss.valid = 1'b0;
    idle.stall = 1'b0;
    idle.flush = 1'b0;
    issue = idle.iss;
    stall = 1'b0;
    flush = 1'b0;
    guard = 0;
    while ((sb.size() > 0 || cur_valid) && guard < DRAIN_LIMIT) begin
      advance_model(idle);
      @(negedge CLK);
      check_output(idle.name);
      guard++;
    end
    if (sb.size() == 0 && !cur_valid) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("pipe did not deliver every expected result before the timeout");
      $display("Test failures found");
      $fatal(1, "drain incomplete");
    end
  end

endmodule

// ==== flist.f ====
hw/vx_pkg.sv
hw/vx_lane_alu.sv
hw/vx_operand_stage.sv
hw/vx_alu_stage.sv
hw/vx_reduce_stage.sv
hw/vx_execute.sv
dv/vx_execute_chk.sv
dv/vx_execute_tb.sv

// ==== hw/vx_alu_stage.sv ====
//**********************************************************************
// execute stage 2: both lanes through the element ALU
// registers lane results with the control fields
//**********************************************************************
`timescale 1ns/100ps

module vx_alu_stage (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  stall,
  input  logic                  flush,
  input  vx_pkg::operand_t      opnd,
  output vx_pkg::lane_result_t  lres
);

  import vx_pkg::*;

  word_t [NUM_LANES-1:0] lane_y;

  // one ALU per lane
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    vx_lane_alu u_alu (
      .op  (opnd.op),
      .sew (opnd.sew),
      .a   (opnd.a[i]),
      .b   (opnd.b[i]),
      .y   (lane_y[i])
    );
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lres <= '0;
    end else if (flush) begin
      lres.valid <= 1'b0;
    end else if (!stall) begin
      lres.valid  <= opnd.valid;
      lres.op     <= opnd.op;
      lres.sew    <= opnd.sew;
      lres.reduce <= opnd.reduce;
      lres.vd     <= opnd.vd;
      lres.r      <= lane_y;
    end
  end

endmodule

// ==== hw/vx_execute.sv ====
//**********************************************************************
// vector execute top, three-stage pipe from decode to memory
// result appears three unstalled edges after issue
//**********************************************************************
`timescale 1ns/100ps

module vx_execute (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  stall,
  input  logic                  flush,
  input  vx_pkg::issue_t        issue,
  output vx_pkg::exec_result_t  result
);

  import vx_pkg::*;

  operand_t     opnd;
  lane_result_t lres;

  vx_operand_stage u_operand (
    .CLK   (CLK),
    .nRST  (nRST),
    .stall (stall),
    .flush (flush),
    .issue (issue),
    .opnd  (opnd)
  );

  vx_alu_stage u_alu (
    .CLK   (CLK),
    .nRST  (nRST),
    .stall (stall),
    .flush (flush),
    .opnd  (opnd),
    .lres  (lres)
  );

  vx_reduce_stage u_reduce (
    .CLK    (CLK),
    .nRST   (nRST),
    .stall  (stall),
    .flush  (flush),
    .lres   (lres),
    .result (result)
  );

endmodule

// ==== hw/vx_lane_alu.sv ====
//**********************************************************************
// combinational element ALU, one per lane plus one for reductions
// signed min/max compare only the low sew bits of each word
//**********************************************************************
`timescale 1ns/100ps

module vx_lane_alu (
  input  vx_pkg::valu_op_t  op,
  input  vx_pkg::sew_t      sew,
  input  vx_pkg::word_t     a,
  input  vx_pkg::word_t     b,
  output vx_pkg::word_t     y
);

  import vx_pkg::*;

  logic slt;
  logic sltu;

  // a < b, signed at the element width
  always_comb begin
    case (sew)
      SEW8:    slt = $signed(a[7:0]) < $signed(b[7:0]);
      SEW16:   slt = $signed(a[15:0]) < $signed(b[15:0]);
      default: slt = $signed(a) < $signed(b);
    endcase
  end

  // unsigned forms always use the full word
  assign sltu = a < b;

  always_comb begin
    case (op)
      VALU_ADD:  y = a + b;
      VALU_AND:  y = a & b;
      VALU_OR:   y = a | b;
      VALU_XOR:  y = a ^ b;
      VALU_MIN:  y = slt ? a : b;
      VALU_MINU: y = sltu ? a : b;
      VALU_MAX:  y = slt ? b : a;
      VALU_MAXU: y = sltu ? b : a;
      default:   y = '0;
    endcase
  end

endmodule

// ==== hw/vx_operand_stage.sv ====
//**********************************************************************
// execute stage 1: picks the a and b operand for each lane
// broadcasts immediate and scalar sources, holds on stall
//**********************************************************************
`timescale 1ns/100ps

module vx_operand_stage (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              stall,
  input  logic              flush,
  input  vx_pkg::issue_t    issue,
  output vx_pkg::operand_t  opnd
);

  import vx_pkg::*;

  word_t [NUM_LANES-1:0] sel_a;
  word_t [NUM_LANES-1:0] sel_b;

  // one lane's source mux
  function automatic word_t pick_src(input src_type_t src, input word_t vec,
                                     input word_t imm, input word_t xs1);
    word_t val;
    case (src)
      SRC_V:   val = vec;
      SRC_I:   val = imm;
      SRC_X:   val = xs1;
      default: val = '0;
    endcase
    return val;
  endfunction

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      sel_a[i] = pick_src(issue.rs1_type, issue.vs1[i], issue.imm, issue.xs1);
      sel_b[i] = pick_src(issue.rs2_type, issue.vs2[i], issue.imm, issue.xs1);
    end
  end

  // flush takes priority over stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      opnd <= '0;
    end else if (flush) begin
      opnd.valid <= 1'b0;
    end else if (!stall) begin
      opnd.valid  <= issue.valid;
      opnd.op     <= issue.op;
      opnd.sew    <= issue.sew;
      opnd.reduce <= issue.reduce;
      opnd.vd     <= issue.vd;
      opnd.a      <= sel_a;
      opnd.b      <= sel_b;
    end
  end

endmodule

// ==== hw/vx_pkg.sv ====
//**********************************************************************
// shared types for the two-lane vector execute pipeline
// import into each stage for the element, opcode and stage structs
//**********************************************************************
package vx_pkg;

  localparam int NUM_LANES = 2;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  vreg_t;

  // integer ALU opcodes
  typedef enum logic [2:0] {
    VALU_ADD  = 3'd0,
    VALU_AND  = 3'd1,
    VALU_OR   = 3'd2,
    VALU_XOR  = 3'd3,
    VALU_MIN  = 3'd4,
    VALU_MINU = 3'd5,
    VALU_MAX  = 3'd6,
    VALU_MAXU = 3'd7
  } valu_op_t;

  // operand source, SRC_NONE reads as zero
  typedef enum logic [1:0] {
    SRC_V    = 2'd0,
    SRC_I    = 2'd1,
    SRC_X    = 2'd2,
    SRC_NONE = 2'd3
  } src_type_t;

  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // from decode, imm and xs1 already sign-extended
  typedef struct packed {
    logic                        valid;
    valu_op_t                    op;
    src_type_t                   rs1_type;
    src_type_t                   rs2_type;
    sew_t                        sew;
    logic                        reduce;
    vreg_t                       vd;
    word_t [NUM_LANES-1:0]       vs1;
    word_t [NUM_LANES-1:0]       vs2;
    word_t                       imm;
    word_t                       xs1;
  } issue_t;

  // stage 1 to stage 2
  typedef struct packed {
    logic                        valid;
    valu_op_t                    op;
    sew_t                        sew;
    logic                        reduce;
    vreg_t                       vd;
    word_t [NUM_LANES-1:0]       a;
    word_t [NUM_LANES-1:0]       b;
  } operand_t;

  // stage 2 to stage 3
  typedef struct packed {
    logic                        valid;
    valu_op_t                    op;
    sew_t                        sew;
    logic                        reduce;
    vreg_t                       vd;
    word_t [NUM_LANES-1:0]       r;
  } lane_result_t;

  // hand-off to the memory stage
  typedef struct packed {
    logic                        valid;
    vreg_t                       vd;
    word_t                       res0;
    word_t                       res1;
  } exec_result_t;

endpackage

// ==== hw/vx_reduce_stage.sv ====
//**********************************************************************
// execute stage 3: folds lane 1 into lane 0 on reductions
// output register is the hand-off to the memory stage
//**********************************************************************
`timescale 1ns/100ps

module vx_reduce_stage (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  stall,
  input  logic                  flush,
  input  vx_pkg::lane_result_t  lres,
  output vx_pkg::exec_result_t  result
);

  import vx_pkg::*;

  word_t fold;
  word_t res0_next;

  // r0 op r1, same compare rules as the lanes
  vx_lane_alu u_fold (
    .op  (lres.op),
    .sew (lres.sew),
    .a   (lres.r[0]),
    .b   (lres.r[1]),
    .y   (fold)
  );

  assign res0_next = lres.reduce ? fold : lres.r[0];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      result <= '0;
    end else if (flush) begin
      result.valid <= 1'b0;
    end else if (!stall) begin
      result.valid <= lres.valid;
      result.vd    <= lres.vd;
      result.res0  <= res0_next;
      // lane 1 passes through unchanged
      result.res1  <= lres.r[1];
    end
  end

endmodule
